/* filelist.f */
logic/mem_cfg_pkg.sv
logic/mem_access_pkg.sv
logic/word_ram.sv
logic/store_merge.sv
logic/load_extract.sv
logic/clear_counter.sv
logic/access_ctrl.sv
logic/data_memory.sv
test/tb_data_memory.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_data_memory -f filelist.f -o tb_data_memory \
   || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_data_memory)
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* test/tb_data_memory.sv */
`timescale 1ns/1ps

module tb_data_memory;

   localparam int max_requests   = 300;
   localparam int random_limit   = 280;
   localparam int timeout_cycles = mem_cfg_pkg::depth + max_requests * 4 + 50;

   logic                              clk;
   logic                              rst;
   logic [mem_cfg_pkg::addr_bits-1:0] fetch_addr;
   logic [mem_cfg_pkg::word_bits-1:0] instr;
   logic                              req;
   mem_access_pkg::mem_req_t          req_in;
   logic                              ready;
   logic                              done;
   mem_access_pkg::mem_rsp_t          rsp;

   logic [31:0]                       lfsr;
   logic [mem_cfg_pkg::word_bits-1:0] model_mem [mem_cfg_pkg::depth];
   mem_access_pkg::mem_rsp_t          model_rsp;
   int cycle_count;
   int request_count;
   int rsp_errors;
   int word_errors;
   int flag_errors;
   int other_errors;

   data_memory uut
   (
      .clk        (clk),
      .rst        (rst),
      .fetch_addr (fetch_addr),
      .instr      (instr),
      .req        (req),
      .req_in     (req_in),
      .ready      (ready),
      .done       (done),
      .rsp        (rsp)
   );

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= timeout_cycles)
      begin
         $display("run timed out after %0d cycles", cycle_count);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      if (state[0])
      begin
         return (state >> 1) ^ 32'h8020_0003;
      end
      return state >> 1;
   endfunction

   task automatic draw_bits(input int count, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < count; i++)
      begin
         lfsr  = lfsr_step(lfsr);
         value = {value[30:0], lfsr[0]};
      end
   endtask

   function automatic mem_access_pkg::mem_op_t pick_op(input logic [2:0] sel);
      case (sel)
         3'd0: return mem_access_pkg::op_lb;
         3'd1: return mem_access_pkg::op_lh;
         3'd2: return mem_access_pkg::op_lw;
         3'd3: return mem_access_pkg::op_lbu;
         3'd4: return mem_access_pkg::op_lhu;
         3'd5: return mem_access_pkg::op_sb;
         3'd6: return mem_access_pkg::op_sh;
         default: return mem_access_pkg::op_sw;
      endcase
   endfunction

   // upper bits are random to exercise the wrap while the word stays below 32
   task automatic make_req(output mem_access_pkg::mem_req_t r);
      logic [31:0] sel;
      logic [31:0] upper;
      logic [31:0] low;
      logic [31:0] data;
      draw_bits(3, sel);
      draw_bits(22, upper);
      draw_bits(7, low);
      draw_bits(32, data);
      r.op    = pick_op(sel[2:0]);
      r.addr  = {upper[21:0], 3'b000, low[6:0]};
      r.wdata = data;
   endtask

   function automatic logic [31:0] model_merge(input mem_access_pkg::mem_op_t op,
      input logic [1:0] off, input logic [31:0] old_word, input logic [31:0] wdata);
      int          shift;
      logic [31:0] mask;
      shift = 0;
      mask  = 32'hffff_ffff;
      if (op == mem_access_pkg::op_sb)
      begin
         shift = 8 * off;
         mask  = 32'h0000_00ff << shift;
      end
      else if (op == mem_access_pkg::op_sh)
      begin
         shift = off[1] ? 16 : 0;
         mask  = 32'h0000_ffff << shift;
      end
      return (old_word & ~mask) | ((wdata << shift) & mask);
   endfunction

   function automatic logic [31:0] model_extract(input mem_access_pkg::mem_op_t op,
      input logic [1:0] off, input logic [31:0] word);
      logic [31:0] lane;
      lane = word;
      if (op inside {mem_access_pkg::op_lb, mem_access_pkg::op_lbu})
      begin
         lane = (word >> (8 * off)) & 32'h0000_00ff;
      end
      else if (op inside {mem_access_pkg::op_lh, mem_access_pkg::op_lhu})
      begin
         lane = (word >> (off[1] ? 16 : 0)) & 32'h0000_ffff;
      end
      if (op == mem_access_pkg::op_lb && lane[7])
      begin
         lane = lane | 32'hffff_ff00;
      end
      if (op == mem_access_pkg::op_lh && lane[15])
      begin
         lane = lane | 32'hffff_0000;
      end
      return lane;
   endfunction

   task automatic check_rsp(input string name, input mem_access_pkg::mem_rsp_t got,
      input mem_access_pkg::mem_rsp_t expected);
      if (got !== expected)
      begin
         rsp_errors++;
         $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, expected);
      end
   endtask

   task automatic check_word(input string name, input logic [mem_cfg_pkg::word_bits-1:0] got,
      input logic [mem_cfg_pkg::word_bits-1:0] expected);
      if (got !== expected)
      begin
         word_errors++;
         $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, expected);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic expected);
      if (got !== expected)
      begin
         flag_errors++;
         $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, name, got, expected);
      end
   endtask

   task automatic step_clk();
      @(posedge clk);
      #1;
   endtask

   // one access, then a fresh fetch address is checked within the done cycle
   task automatic run_access(input mem_access_pkg::mem_req_t r, input bit junk);
      int                       edges;
      logic [7:0]               widx;
      logic [31:0]              bits;
      mem_access_pkg::mem_req_t junk_req;
      widx = r.addr[mem_cfg_pkg::index_lsb +: mem_cfg_pkg::index_bits];
      check_flag("ready", ready, 1'b1);
      req    = 1'b1;
      req_in = r;
      request_count++;
      step_clk();
      req   = 1'b0;
      edges = 1;
      check_flag("ready", ready, 1'b0);
      check_flag("done", done, 1'b0);
      // a store pulsed in the busy cycle must be dropped
      if (junk)
      begin
         junk_req.op    = mem_access_pkg::op_sw;
         junk_req.addr  = r.addr;
         junk_req.wdata = ~r.wdata;
         req            = 1'b1;
         req_in         = junk_req;
      end
      if (r.op inside {mem_access_pkg::op_sb, mem_access_pkg::op_sh, mem_access_pkg::op_sw})
      begin
         model_mem[widx] = model_merge(r.op, r.addr[1:0], model_mem[widx], r.wdata);
      end
      else
      begin
         model_rsp.rdata = model_extract(r.op, r.addr[1:0], model_mem[widx]);
      end
      while (done !== 1'b1 && edges < 4)
      begin
         step_clk();
         req = 1'b0;
         edges++;
      end
      if (edges != 2)
      begin
         other_errors++;
         $display("done for %s at %h came %0d edges after capture instead of 2",
                  r.op.name(), r.addr, edges);
      end
      check_flag("ready", ready, 1'b1);
      check_rsp("rsp", rsp, model_rsp);
      draw_bits(32, bits);
      fetch_addr = {bits[31:10], 3'b000, bits[6:0]};
      #1;
      check_word("instr", instr, model_mem[fetch_addr[9:2]]);
      step_clk();
      check_flag("done", done, 1'b0);
      check_flag("ready", ready, 1'b1);
   endtask

   initial
   begin
      int                       n;
      logic [31:0]              bits;
      mem_access_pkg::mem_req_t r;
      clk           = 1'b0;
      rst           = 1'b1;
      req           = 1'b0;
      req_in        = '0;
      fetch_addr    = '0;
      lfsr          = 32'h9a1d;
      model_rsp     = '0;
      cycle_count   = 0;
      request_count = 0;
      rsp_errors    = 0;
      word_errors   = 0;
      flag_errors   = 0;
      other_errors  = 0;
      for (int i = 0; i < mem_cfg_pkg::depth; i++)
      begin
         model_mem[i] = '0;
      end
      repeat (3) step_clk();
      check_flag("ready", ready, 1'b0);
      check_flag("done", done, 1'b0);
      rst = 1'b0;

      // stores pulsed during the clear sweep are ignored
      n = 0;
      while (ready !== 1'b1 && n < 300)
      begin
         if (n == 5 || n == 120 || n == 250 || n == 255)
         begin
            make_req(r);
            r.op   = mem_access_pkg::op_sw;
            req    = 1'b1;
            req_in = r;
         end
         step_clk();
         req = 1'b0;
         n++;
         check_flag("done", done, 1'b0);
      end
      if (n != mem_cfg_pkg::depth)
      begin
         other_errors++;
         $display("ready rose %0d cycles after reset instead of %0d", n, mem_cfg_pkg::depth);
      end
      check_rsp("rsp", rsp, model_rsp);

      for (int i = 0; i < mem_cfg_pkg::depth; i++)
      begin
         draw_bits(32, bits);
         fetch_addr = {bits[31:10], i[7:0], bits[1:0]};
         step_clk();
         check_word("instr", instr, model_mem[i]);
      end
      for (int i = 0; i < 32; i++)
      begin
         draw_bits(32, bits);
         r.op    = mem_access_pkg::op_lw;
         r.addr  = {bits[31:10], 3'b000, i[4:0], bits[1:0]};
         r.wdata = bits;
         run_access(r, i % 8 == 7);
      end

      // sub-word stores are followed by a word load of the same word
      while (request_count < random_limit)
      begin
         make_req(r);
         run_access(r, request_count % 8 == 3);
         if (r.op inside {mem_access_pkg::op_sb, mem_access_pkg::op_sh})
         begin
            r.op = mem_access_pkg::op_lw;
            run_access(r, 1'b0);
         end
      end

      $display("errors: rsp %0d, word %0d, flag %0d, other %0d",
               rsp_errors, word_errors, flag_errors, other_errors);
      if (rsp_errors + word_errors + flag_errors + other_errors == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* logic/data_memory.sv */
`timescale 1ns/1ps

module data_memory
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic [mem_cfg_pkg::addr_bits-1:0]   fetch_addr,
   output logic [mem_cfg_pkg::word_bits-1:0]   instr,
   input  logic                                req,
   input  mem_access_pkg::mem_req_t            req_in,
   output logic                                ready,
   output logic                                done,
   output mem_access_pkg::mem_rsp_t            rsp
);

   logic                                clear_run;
   logic [mem_cfg_pkg::index_bits-1:0]  clear_index;
   logic                                clear_last;
   mem_access_pkg::mem_req_t            held_req;
   logic [mem_cfg_pkg::word_bits-1:0]   old_word;
   logic [mem_cfg_pkg::word_bits-1:0]   merged_word;
   logic [mem_cfg_pkg::word_bits-1:0]   load_word;
   logic                                wr_en;
   logic [mem_cfg_pkg::index_bits-1:0]  wr_index;
   logic [mem_cfg_pkg::word_bits-1:0]   wr_data;

   access_ctrl u_ctrl
   (
      .clk         (clk),
      .rst         (rst),
      .req         (req),
      .req_in      (req_in),
      .clear_index (clear_index),
      .clear_last  (clear_last),
      .clear_run   (clear_run),
      .merged_word (merged_word),
      .load_word   (load_word),
      .held_req    (held_req),
      .wr_en       (wr_en),
      .wr_index    (wr_index),
      .wr_data     (wr_data),
      .ready       (ready),
      .done        (done),
      .rsp         (rsp)
   );

   clear_counter u_clear
   (
      .clk         (clk),
      .rst         (rst),
      .clear_run   (clear_run),
      .clear_index (clear_index),
      .clear_last  (clear_last)
   );

   // upper address bits are dropped here, so both ports wrap
   word_ram u_ram
   (
      .clk        (clk),
      .wr_en      (wr_en),
      .wr_index   (wr_index),
      .wr_data    (wr_data),
      .rd_index_a (fetch_addr[mem_cfg_pkg::index_lsb +: mem_cfg_pkg::index_bits]),
      .rd_data_a  (instr),
      .rd_index_b (held_req.addr[mem_cfg_pkg::index_lsb +: mem_cfg_pkg::index_bits]),
      .rd_data_b  (old_word)
   );

   store_merge u_merge
   (
      .req         (held_req),
      .old_word    (old_word),
      .merged_word (merged_word)
   );

   load_extract u_extract
   (
      .req       (held_req),
      .old_word  (old_word),
      .load_word (load_word)
   );

endmodule

/* logic/access_ctrl.sv */
`timescale 1ns/1ps

module access_ctrl
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                req,
   input  mem_access_pkg::mem_req_t            req_in,
   input  logic [mem_cfg_pkg::index_bits-1:0]  clear_index,
   input  logic                                clear_last,
   output logic                                clear_run,
   input  logic [mem_cfg_pkg::word_bits-1:0]   merged_word,
   input  logic [mem_cfg_pkg::word_bits-1:0]   load_word,
   output mem_access_pkg::mem_req_t            held_req,
   output logic                                wr_en,
   output logic [mem_cfg_pkg::index_bits-1:0]  wr_index,
   output logic [mem_cfg_pkg::word_bits-1:0]   wr_data,
   output logic                                ready,
   output logic                                done,
   output mem_access_pkg::mem_rsp_t            rsp
);

   mem_access_pkg::ctrl_state_t state;
   logic                        is_store;

   assign is_store = held_req.op inside {mem_access_pkg::op_sb, mem_access_pkg::op_sh,
                                         mem_access_pkg::op_sw};

   assign clear_run = (state == mem_access_pkg::st_clear);
   assign ready     = (state == mem_access_pkg::st_idle);

   // the sweep owns the write port until it finishes
   always_comb
   begin
      wr_en    = 1'b0;
      wr_index = held_req.addr[mem_cfg_pkg::index_lsb +: mem_cfg_pkg::index_bits];
      wr_data  = merged_word;
      if (state == mem_access_pkg::st_clear)
      begin
         wr_en    = 1'b1;
         wr_index = clear_index;
         wr_data  = '0;
      end
      else if (state == mem_access_pkg::st_access)
      begin
         wr_en = is_store;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= mem_access_pkg::st_clear;
         done  <= 1'b0;
         rsp   <= '0;
      end
      else
      begin
         done <= 1'b0;
         case (state)
            mem_access_pkg::st_clear:
            begin
               if (clear_last)
               begin
                  state <= mem_access_pkg::st_idle;
               end
            end
            mem_access_pkg::st_idle:
            begin
               if (req)
               begin
                  state <= mem_access_pkg::st_access;
               end
            end
            mem_access_pkg::st_access:
            begin
               // stores keep the last load result in rsp
               if (!is_store)
               begin
                  rsp.rdata <= load_word;
               end
               done  <= 1'b1;
               state <= mem_access_pkg::st_idle;
            end
            default:
            begin
               state <= mem_access_pkg::st_clear;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (ready && req)
      begin
         held_req <= req_in;
      end
   end

endmodule

/* logic/clear_counter.sv */
`timescale 1ns/1ps

module clear_counter
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                clear_run,
   output logic [mem_cfg_pkg::index_bits-1:0]  clear_index,
   output logic                                clear_last
);

   localparam logic [mem_cfg_pkg::index_bits-1:0] last_index =
      mem_cfg_pkg::index_bits'(mem_cfg_pkg::depth - 1);

   // wraps back to 0 on the edge that writes the last word
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         clear_index <= '0;
      end
      else if (clear_run)
      begin
         clear_index <= clear_index + 1'b1;
      end
   end

   assign clear_last = (clear_index == last_index);

endmodule

/* logic/load_extract.sv */
`timescale 1ns/1ps

module load_extract
(
   input  mem_access_pkg::mem_req_t            req,
   input  logic [mem_cfg_pkg::word_bits-1:0]   old_word,
   output logic [mem_cfg_pkg::word_bits-1:0]   load_word
);

   logic [7:0]  byte_lane;
   logic [15:0] half_lane;

   assign byte_lane = old_word[{req.addr[1:0], 3'b000} +: 8];
   assign half_lane = req.addr[1] ? old_word[31:16] : old_word[15:0];

   always_comb
   begin
      case (req.op)
         mem_access_pkg::op_lb:
         begin
            load_word = {{(mem_cfg_pkg::word_bits-8){byte_lane[7]}}, byte_lane};
         end
         mem_access_pkg::op_lbu:
         begin
            load_word = {{(mem_cfg_pkg::word_bits-8){1'b0}}, byte_lane};
         end
         mem_access_pkg::op_lh:
         begin
            load_word = {{(mem_cfg_pkg::word_bits-16){half_lane[15]}}, half_lane};
         end
         mem_access_pkg::op_lhu:
         begin
            load_word = {{(mem_cfg_pkg::word_bits-16){1'b0}}, half_lane};
         end
         // op_lw and the store ops see the whole word
         default:
         begin
            load_word = old_word;
         end
      endcase
   end

endmodule

/* logic/store_merge.sv */
`timescale 1ns/1ps

module store_merge
(
   input  mem_access_pkg::mem_req_t            req,
   input  logic [mem_cfg_pkg::word_bits-1:0]   old_word,
   output logic [mem_cfg_pkg::word_bits-1:0]   merged_word
);

   always_comb
   begin
      merged_word = old_word;
      case (req.op)
         mem_access_pkg::op_sb:
         begin
            merged_word[{req.addr[1:0], 3'b000} +: 8] = req.wdata[7:0];
         end
         mem_access_pkg::op_sh:
         begin
            // only offset bit 1 counts, bit 0 is ignored
            if (req.addr[1])
            begin
               merged_word[31:16] = req.wdata[15:0];
            end
            else
            begin
               merged_word[15:0] = req.wdata[15:0];
            end
         end
         mem_access_pkg::op_sw:
         begin
            merged_word = req.wdata;
         end
         default:
         begin
            merged_word = old_word;
         end
      endcase
   end

endmodule

/* logic/word_ram.sv */
`timescale 1ns/1ps

module word_ram
(
   input  logic                                clk,
   input  logic                                wr_en,
   input  logic [mem_cfg_pkg::index_bits-1:0]  wr_index,
   input  logic [mem_cfg_pkg::word_bits-1:0]   wr_data,
   input  logic [mem_cfg_pkg::index_bits-1:0]  rd_index_a,
   output logic [mem_cfg_pkg::word_bits-1:0]   rd_data_a,
   input  logic [mem_cfg_pkg::index_bits-1:0]  rd_index_b,
   output logic [mem_cfg_pkg::word_bits-1:0]   rd_data_b
);

   logic [mem_cfg_pkg::word_bits-1:0] mem [mem_cfg_pkg::depth];

   // whole words only, sub-word stores are merged before they get here
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_index] <= wr_data;
      end
   end

   // port a serves instruction fetch, port b the data side
   assign rd_data_a = mem[rd_index_a];
   assign rd_data_b = mem[rd_index_b];

endmodule

/* logic/mem_access_pkg.sv */
package mem_access_pkg;

   // bits 1:0 give the size (byte, half, word), bit 2 marks an unsigned load
   // and bit 3 marks a store
   typedef enum logic [3:0]
   {
      op_lb  = 4'b0000,
      op_lh  = 4'b0001,
      op_lw  = 4'b0010,
      op_lbu = 4'b0100,
      op_lhu = 4'b0101,
      op_sb  = 4'b1000,
      op_sh  = 4'b1001,
      op_sw  = 4'b1010
   } mem_op_t;

   typedef enum logic [1:0]
   {
      st_clear  = 2'b00,
      st_idle   = 2'b01,
      st_access = 2'b10
   } ctrl_state_t;

   typedef struct packed
   {
      mem_op_t                             op;
      logic [mem_cfg_pkg::addr_bits-1:0]   addr;
      logic [mem_cfg_pkg::word_bits-1:0]   wdata;
   } mem_req_t;

   typedef struct packed
   {
      logic [mem_cfg_pkg::word_bits-1:0]   rdata;
   } mem_rsp_t;

endpackage

/* logic/mem_cfg_pkg.sv */
package mem_cfg_pkg;

   // data word and byte address widths
   localparam int word_bits = 32;
   localparam int addr_bits = 32;

   // 256 words, so a word index is 8 bits wide
   localparam int depth = 256;
   localparam int index_bits = 8;

   // the word index starts above the two byte offset bits
   localparam int index_lsb = 2;

endpackage
